// File: compile.f
ooo_pkg.sv
free_list.sv
map_table.sv
phys_regfile.sv
exec_unit.sv
reorder_buffer.sv
ooo_pipeline.sv
tb_ooo_pipeline.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_ooo_pipeline \
  -f compile.f -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

// File: tb_ooo_pipeline.sv
////////////////////////////////////////
// ooo core testbench
// directed tests against an in-order
// commit queue built at dispatch
////////////////////////////////////////

`timescale 1ns/1ps

module tb_ooo_pipeline;

  localparam int rob_depth      = 8;
  localparam int timeout_cycles = 3000;  // ~120 instrs at up to 8 cycles, plus margin
  localparam int drain_cycles   = 64;    // far past a full rob at latency 7

  logic                   clock;
  logic                   reset;
  logic                   dispatch_valid;
  ooo_pkg::dispatch_pkt_t dispatch_pkt;
  logic                   dispatch_ready;
  ooo_pkg::commit_t       commit;
  logic [15:0]            retired_count;

  ooo_pkg::commit_t exp_q [$];  // expected commits in dispatch order
  ooo_pkg::commit_t exp_front;
  string            cur_test;
  int               error_count;
  int               commit_count;
  int               sent_count;
  int               cycle_count;
  integer           seed;
  logic [31:0]      next_pc;
  logic             ready_fell;   // set once dispatch_ready is seen low

  ooo_pipeline #(.rob_depth(rob_depth)) i_ooo_pipeline (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch_pkt   (dispatch_pkt),
    .dispatch_ready (dispatch_ready),
    .commit         (commit),
    .retired_count  (retired_count)
  );

  always #4 clock = ~clock;  // 8 ns period

  ////////////////////////////////////////
  // timeout and monitor
  ////////////////////////////////////////

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles in %s, %0d commits still outstanding",
               cycle_count, cur_test, exp_q.size());
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("[ERROR] %s: %s expected %0h actual %0h", cur_test, what, expected, actual);
    end
  endtask

  // sample mid-cycle, away from the rising edge
  always @(negedge clock) begin
    if (!reset && !dispatch_ready) begin
      ready_fell = 1'b1;
    end
    if (!reset && commit.valid) begin
      commit_count++;
      if (exp_q.size() == 0) begin
        error_count++;
        $display("%s: commit at pc %0h with no instruction outstanding", cur_test, commit.pc);
      end else begin
        exp_front = exp_q.pop_front();
        check_equal("commit dest", 32'(exp_front.arch_idx), 32'(commit.arch_idx));
        check_equal("commit data", exp_front.data, commit.data);
        check_equal("commit pc", exp_front.pc, commit.pc);
      end
    end
  end

  ////////////////////////////////////////
  // driver helpers
  ////////////////////////////////////////

  // called 1 ns after an edge, returns 1 ns after the accept edge
  task automatic send_pkt(input ooo_pkg::arch_idx_t dest, input logic [15:0] a,
                          input logic [15:0] b, input logic [2:0] lat);
    ooo_pkg::commit_t e;
    while (!dispatch_ready) begin  // registered level is stable here
      @(posedge clock);
      #1;
    end
    dispatch_valid         = 1'b1;
    dispatch_pkt.dest_arch = dest;
    dispatch_pkt.op_a      = a;
    dispatch_pkt.op_b      = b;
    dispatch_pkt.latency   = lat;
    dispatch_pkt.pc        = next_pc;
    e.valid    = 1'b1;
    e.arch_idx = dest;
    e.data     = 32'(a) * 32'(b);  // unsigned 16x16 product
    e.pc       = next_pc;
    exp_q.push_back(e);
    sent_count++;
    next_pc = next_pc + 32'd4;
    @(posedge clock);
    #1;
    dispatch_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  // run until every queued commit is seen or the drain bound runs out,
  // then a few quiet cycles
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_cycles) begin
      @(posedge clock);
      #1;
      waited++;
    end
    idle_cycles(3);  // a stray extra commit shows up here
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    cur_test = "test_reset_state";
    check_equal("dispatch_ready", 32'd1, 32'(dispatch_ready));
    check_equal("retired_count", 32'd0, 32'(retired_count));
    for (int i = 0; i < 10; i++) begin
      if (commit.valid !== 1'b0) begin
        error_count++;
        $display("%s: commit.valid high while idle after reset", cur_test);
      end
      idle_cycles(1);
    end
  endtask

  task automatic test_single();
    int start;
    cur_test = "test_single";
    start    = commit_count;
    send_pkt(3'd5, 16'h1234, 16'h0056, 3'd3);
    wait_drain();
    check_equal("commit count", 32'(start + 1), 32'(commit_count));
  endtask

  // completes in reverse, must still commit in order
  task automatic test_reverse_latency();
    int start;
    cur_test = "test_reverse_latency";
    start    = commit_count;
    for (int i = 0; i < 8; i++) begin
      send_pkt(3'(i), 16'(16'h0100 + i), 16'(16'h0011 * (i + 1)), 3'((i < 7) ? 7 - i : 1));
    end
    wait_drain();
    check_equal("commit count", 32'(start + 8), 32'(commit_count));
  endtask

  task automatic test_rob_full();
    int start;
    cur_test   = "test_rob_full";
    start      = commit_count;
    ready_fell = 1'b0;
    for (int i = 0; i < 12; i++) begin
      send_pkt(3'(i % 8), 16'(16'hff00 + i), 16'(16'h0303 + i), 3'd7);
    end
    wait_drain();
    if (!ready_fell) begin
      error_count++;
      $display("%s: dispatch_ready never fell with the ROB full", cur_test);
    end
    check_equal("commit count", 32'(start + 12), 32'(commit_count));
  endtask

  task automatic test_random_stream();
    logic [31:0] r1;
    logic [31:0] r2;
    cur_test = "test_random_stream";
    for (int i = 0; i < 100; i++) begin
      r1 = $random(seed);
      r2 = $random(seed);
      send_pkt(r1[2:0], r1[18:3], r2[15:0], 3'(1 + (r2[23:16] % 7)));
      if (r1[31:29] == 3'd0) begin
        idle_cycles(1);  // occasional gap in the stream
      end
    end
    wait_drain();
    check_equal("retired_count", 32'(sent_count), 32'(retired_count));
    check_equal("queue size", 32'd0, 32'(exp_q.size()));
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_pkt   = '0;
    cur_test       = "reset";
    error_count    = 0;
    commit_count   = 0;
    sent_count     = 0;
    cycle_count    = 0;
    seed           = 36039;
    next_pc        = 32'h0000_1000;
    ready_fell     = 1'b0;
    repeat (5) @(posedge clock);  // 5 cycles of reset
    #1;
    reset = 1'b0;
    test_reset_state();
    test_single();
    test_reverse_latency();
    test_rob_full();
    test_random_stream();
    $display("errors %0d, dispatched %0d, committed %0d, cycles %0d",
             error_count, sent_count, commit_count, cycle_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: ooo_pipeline.sv
////////////////////////////////////////
// out-of-order core top level
// rename, execute, complete on the cdb,
// retire in order through the rob
////////////////////////////////////////

`timescale 1ns/1ps

module ooo_pipeline #(
  parameter int rob_depth = 8  // 2..8, need not be a power of two
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch_valid,  // single-cycle strobe
  input  ooo_pkg::dispatch_pkt_t dispatch_pkt,
  output logic                   dispatch_ready,
  output ooo_pkg::commit_t       commit,
  output logic [15:0]            retired_count
);

  logic               accept;
  ooo_pkg::rob_idx_t  tail_idx;
  ooo_pkg::phys_idx_t head_phys;   // next free reg
  ooo_pkg::rename_t   rename;
  ooo_pkg::cdb_t      cdb;
  ooo_pkg::phys_idx_t retire_phys;
  logic [31:0]        retire_data;
  logic               free_push;
  ooo_pkg::phys_idx_t free_phys;

  ////////////////////////////////////////
  // dispatch / rename
  ////////////////////////////////////////

  free_list i_free_list (
    .clock     (clock),
    .reset     (reset),
    .accept    (accept),
    .free_push (free_push),
    .free_phys (free_phys),
    .head_phys (head_phys)
  );

  map_table i_map_table (
    .clock     (clock),
    .reset     (reset),
    .accept    (accept),
    .dest_arch (dispatch_pkt.dest_arch),
    .new_phys  (head_phys),
    .rename    (rename)
  );

  ////////////////////////////////////////
  // execute / complete
  ////////////////////////////////////////

  exec_unit #(.rob_depth(rob_depth)) i_exec_unit (
    .clock    (clock),
    .reset    (reset),
    .accept   (accept),
    .tail_idx (tail_idx),
    .pkt      (dispatch_pkt),
    .new_phys (head_phys),
    .cdb      (cdb)
  );

  phys_regfile i_phys_regfile (
    .clock     (clock),
    .reset     (reset),
    .cdb       (cdb),
    .read_idx  (retire_phys),
    .read_data (retire_data)
  );

  // window and retire
  reorder_buffer #(.rob_depth(rob_depth)) i_reorder_buffer (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .pkt            (dispatch_pkt),
    .rename         (rename),
    .cdb            (cdb),
    .retire_data    (retire_data),
    .accept         (accept),
    .dispatch_ready (dispatch_ready),
    .tail_idx       (tail_idx),
    .retire_phys    (retire_phys),
    .free_push      (free_push),
    .free_phys      (free_phys),
    .commit         (commit),
    .retired_count  (retired_count)
  );

endmodule

// File: reorder_buffer.sv
////////////////////////////////////////
// reorder buffer
// in-order window that accepts dispatch,
// marks cdb completions, retires one per cycle
////////////////////////////////////////

`timescale 1ns/1ps

module reorder_buffer #(
  parameter int rob_depth = 8
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch_valid,
  input  ooo_pkg::dispatch_pkt_t pkt,
  input  ooo_pkg::rename_t       rename,
  input  ooo_pkg::cdb_t          cdb,
  input  logic [31:0]            retire_data,    // prf read of retire_phys
  output logic                   accept,
  output logic                   dispatch_ready,
  output ooo_pkg::rob_idx_t      tail_idx,
  output ooo_pkg::phys_idx_t     retire_phys,
  output logic                   free_push,
  output ooo_pkg::phys_idx_t     free_phys,
  output ooo_pkg::commit_t       commit,
  output logic [15:0]            retired_count
);

  localparam int cnt_w = $clog2(ooo_pkg::max_rob_depth + 1);

  typedef struct packed {
    ooo_pkg::arch_idx_t dest_arch;
    logic [31:0]        pc;
    ooo_pkg::phys_idx_t new_phys;
    ooo_pkg::phys_idx_t old_phys;
  } rob_entry_t;

  rob_entry_t           entry [rob_depth];
  logic [rob_depth-1:0] valid;  // slot occupied
  logic [rob_depth-1:0] done;   // result on the cdb already
  ooo_pkg::rob_idx_t    head;
  ooo_pkg::rob_idx_t    tail;
  logic [cnt_w-1:0]     count;
  logic [cnt_w-1:0]     count_next;
  logic                 retire;

  function automatic ooo_pkg::rob_idx_t wrap_inc(ooo_pkg::rob_idx_t idx);
    return (idx == ooo_pkg::rob_idx_t'(rob_depth - 1)) ? '0 : idx + 1'b1;
  endfunction

  assign accept      = dispatch_valid && dispatch_ready;  // strobe while full is dropped
  assign retire      = valid[head] && done[head];        // never stalls once done
  assign tail_idx    = tail;
  assign retire_phys = entry[head].new_phys;
  assign free_push   = retire;
  assign free_phys   = entry[head].old_phys;             // previous mapping goes back
  assign count_next  = count + cnt_w'(accept) - cnt_w'(retire);

  ////////////////////////////////////////
  // pointers and flags
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      valid          <= '0;
      done           <= '0;
      dispatch_ready <= 1'b1;
      retired_count  <= '0;
    end else begin
      count          <= count_next;
      dispatch_ready <= count_next != cnt_w'(rob_depth);  // low only when full
      if (cdb.valid) begin
        done[cdb.rob_idx] <= 1'b1;
      end
      if (retire) begin
        valid[head]   <= 1'b0;
        head          <= wrap_inc(head);
        retired_count <= retired_count + 16'd1;
      end
      if (accept) begin
        valid[tail] <= 1'b1;
        done[tail]  <= 1'b0;
        tail        <= wrap_inc(tail);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      entry[tail] <= '{dest_arch: pkt.dest_arch, pc: pkt.pc,
                       new_phys: rename.new_phys, old_phys: rename.old_phys};
    end
  end

  // commit report lags retire by one cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      commit.valid <= 1'b0;
    end else begin
      commit.valid    <= retire;
      commit.arch_idx <= entry[head].dest_arch;
      commit.data     <= retire_data;
      commit.pc       <= entry[head].pc;
    end
  end

  rob_cdb_live_slot_a: assert property (@(posedge clock) disable iff (reset)
    cdb.valid |-> valid[cdb.rob_idx]);

  // a full window has no empty slot left at the tail
  rob_no_accept_full_a: assert property (@(posedge clock) disable iff (reset)
    accept |-> !valid[tail]);

endmodule

// File: exec_unit.sv
////////////////////////////////////////
// execution unit
// per rob slot latency countdown, product
// at load, lowest ready slot wins the cdb
////////////////////////////////////////

`timescale 1ns/1ps

module exec_unit #(
  parameter int rob_depth = 8
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   accept,
  input  ooo_pkg::rob_idx_t      tail_idx,   // slot to load
  input  ooo_pkg::dispatch_pkt_t pkt,
  input  ooo_pkg::phys_idx_t     new_phys,
  output ooo_pkg::cdb_t          cdb
);

  logic [rob_depth-1:0] busy;
  logic [2:0]           remaining [rob_depth];  // cycles left before cdb request
  ooo_pkg::phys_idx_t   slot_phys [rob_depth];
  logic [31:0]          product   [rob_depth];

  logic                 win_found;
  ooo_pkg::rob_idx_t    win_idx;

  ////////////////////////////////////////
  // cdb arbitration
  ////////////////////////////////////////

  always_comb begin
    win_found = 1'b0;
    win_idx   = '0;
    // scan high to low so the lowest ready slot is left standing
    for (int i = rob_depth - 1; i >= 0; i--) begin
      if (busy[i] && remaining[i] == 3'd0) begin
        win_found = 1'b1;
        win_idx   = ooo_pkg::rob_idx_t'(i);
      end
    end
  end

  // driven straight from slot registers
  always_comb begin
    cdb.valid    = win_found;
    cdb.rob_idx  = win_idx;
    cdb.phys_idx = slot_phys[win_idx];
    cdb.result   = product[win_idx];
  end

  ////////////////////////////////////////
  // slot state
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
      for (int i = 0; i < rob_depth; i++) begin
        remaining[i] <= '0;
      end
    end else begin
      for (int i = 0; i < rob_depth; i++) begin
        if (remaining[i] != 3'd0) begin
          remaining[i] <= remaining[i] - 3'd1;
        end
      end
      if (win_found) begin
        busy[win_idx] <= 1'b0;  // broadcast done, slot drains
      end
      if (accept) begin
        busy[tail_idx]      <= 1'b1;
        remaining[tail_idx] <= pkt.latency - 3'd1;  // latency 1 requests next cycle
      end
    end
  end

  // payload, computed once at load
  always_ff @(posedge clock) begin
    if (accept) begin
      slot_phys[tail_idx] <= new_phys;
      product[tail_idx]   <= 32'(pkt.op_a) * 32'(pkt.op_b);
    end
  end

  exec_latency_nonzero_a: assert property (@(posedge clock) disable iff (reset)
    accept |-> pkt.latency != 3'd0);

  // rob reuses a slot only after its retire, so the old op has broadcast
  exec_slot_free_a: assert property (@(posedge clock) disable iff (reset)
    accept |-> !busy[tail_idx]);

endmodule

// File: phys_regfile.sv
////////////////////////////////////////
// physical register file
// 16 x 32 storage, cdb write at the edge
////////////////////////////////////////

`timescale 1ns/1ps

module phys_regfile (
  input  logic               clock,
  input  logic               reset,
  input  ooo_pkg::cdb_t      cdb,
  input  ooo_pkg::phys_idx_t read_idx,   // retire read port
  output logic [31:0]        read_data
);

  logic [31:0] regs [ooo_pkg::num_phys_regs];
  logic        fresh;  // phys 8 still untouched since reset

  assign read_data = regs[read_idx];  // combinational read

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ooo_pkg::num_phys_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (cdb.valid) begin
      regs[cdb.phys_idx] <= cdb.result;
    end
  end

  // phys 8 is the first register renamed, and it must complete before
  // anything retires, so its first write ends the window where regs
  // 0..7 still hold initial state and cannot have been recycled
  always_ff @(posedge clock) begin
    if (reset) begin
      fresh <= 1'b1;
    end else if (cdb.valid && cdb.phys_idx == ooo_pkg::phys_idx_t'(ooo_pkg::num_arch_regs)) begin
      fresh <= 1'b0;
    end
  end

  prf_initial_write_a: assert property (@(posedge clock) disable iff (reset)
    (fresh && cdb.valid) |-> cdb.phys_idx >= ooo_pkg::phys_idx_t'(ooo_pkg::num_arch_regs));

endmodule

// File: map_table.sv
////////////////////////////////////////
// rename map table
// arch to phys mapping, old mapping out,
// new mapping installed on accept
////////////////////////////////////////

`timescale 1ns/1ps

module map_table (
  input  logic               clock,
  input  logic               reset,
  input  logic               accept,
  input  ooo_pkg::arch_idx_t dest_arch,
  input  ooo_pkg::phys_idx_t new_phys,   // free list head
  output ooo_pkg::rename_t   rename
);

  ooo_pkg::phys_idx_t map [ooo_pkg::num_arch_regs];

  // read comes before the write at the edge, so back-to-back
  // renames of one register chain through old_phys
  always_comb begin
    rename.new_phys = new_phys;
    rename.old_phys = map[dest_arch];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ooo_pkg::num_arch_regs; i++) begin
        map[i] <= ooo_pkg::phys_idx_t'(i);  // identity after reset
      end
    end else if (accept) begin
      map[dest_arch] <= new_phys;
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // a register handed out by the free list is never still mapped
  map_fresh_phys_a: assert property (@(posedge clock) disable iff (reset)
    accept |-> new_phys != map[dest_arch]);

endmodule

// File: free_list.sv
////////////////////////////////////////
// free list
// circular queue of free physical regs,
// popped at dispatch, refilled at retire
////////////////////////////////////////

`timescale 1ns/1ps

module free_list (
  input  logic               clock,
  input  logic               reset,
  input  logic               accept,     // pop the head
  input  logic               free_push,  // push from retire
  input  ooo_pkg::phys_idx_t free_phys,
  output ooo_pkg::phys_idx_t head_phys
);

  localparam int fl_depth = ooo_pkg::num_phys_regs - ooo_pkg::num_arch_regs;
  localparam int ptr_w    = $clog2(fl_depth);
  localparam int cnt_w    = $clog2(fl_depth + 1);

  ooo_pkg::phys_idx_t entries [fl_depth];
  logic [ptr_w-1:0]   head;
  logic [ptr_w-1:0]   tail;
  logic [cnt_w-1:0]   count;  // free registers held

  assign head_phys = entries[head];  // next rename target, read in the dispatch cycle

  always_ff @(posedge clock) begin
    if (reset) begin
      // queue starts full with the regs past the identity map
      for (int i = 0; i < fl_depth; i++) begin
        entries[i] <= ooo_pkg::phys_idx_t'(ooo_pkg::num_arch_regs + i);
      end
      head  <= '0;
      tail  <= '0;
      count <= cnt_w'(fl_depth);
    end else begin
      if (accept) begin
        head <= (head == ptr_w'(fl_depth - 1)) ? '0 : head + 1'b1;
      end
      if (free_push) begin
        entries[tail] <= free_phys;
        tail          <= (tail == ptr_w'(fl_depth - 1)) ? '0 : tail + 1'b1;
      end
      // pop and push together leave the count alone
      if (accept && !free_push) begin
        count <= count - 1'b1;
      end else if (free_push && !accept) begin
        count <= count + 1'b1;
      end
    end
  end

  // rob depth bounds the renames outstanding, so a pop always finds a register
  free_list_underflow_a: assert property (@(posedge clock) disable iff (reset)
    accept |-> count != '0);

endmodule

// File: ooo_pkg.sv
////////////////////////////////////////
// ooo core shared definitions
// register counts, index types, dispatch
// packet and the cdb / commit buses
////////////////////////////////////////

package ooo_pkg;

  ////////////////////////////////////////
  // register counts
  ////////////////////////////////////////

  localparam int num_arch_regs = 8;
  localparam int max_rob_depth = 8;  // largest legal rob_depth
  // every in-flight rename needs one spare physical register
  localparam int num_phys_regs = num_arch_regs + max_rob_depth;

  ////////////////////////////////////////
  // index types
  ////////////////////////////////////////

  typedef logic [$clog2(num_arch_regs)-1:0] arch_idx_t;  // 3 bits
  typedef logic [$clog2(num_phys_regs)-1:0] phys_idx_t;  // 4 bits
  typedef logic [$clog2(max_rob_depth)-1:0] rob_idx_t;   // sized for the deepest rob

  ////////////////////////////////////////
  // packets and buses
  ////////////////////////////////////////

  // one dispatched instruction, 70 bits
  typedef struct packed {
    arch_idx_t   dest_arch;
    logic [15:0] op_a;
    logic [15:0] op_b;
    logic [2:0]  latency;  // 1..7 cycles
    logic [31:0] pc;
  } dispatch_pkt_t;

  // rename of one destination
  typedef struct packed {
    phys_idx_t new_phys;
    phys_idx_t old_phys;  // freed when this instruction retires
  } rename_t;

  // completion broadcast
  typedef struct packed {
    logic        valid;
    rob_idx_t    rob_idx;
    phys_idx_t   phys_idx;
    logic [31:0] result;
  } cdb_t;

  // in-order retire report
  typedef struct packed {
    logic        valid;
    arch_idx_t   arch_idx;
    logic [31:0] data;
    logic [31:0] pc;
  } commit_t;

endpackage
